//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN      = 32;            // data and instruction width
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;            // x0 included

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcodes of the base integer set
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_r,      // no immediate, reads as zero
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

endpackage : isa_pkg

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // program counter is as wide as a machine word
    typedef logic [isa_pkg::XLEN-1:0] pc_t;

    // occupancy of the decode output register
    typedef enum logic {
        out_empty,
        out_full
    } out_state_e;

endpackage : pipe_pkg

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter pipe_pkg::pc_t RESET_PC = 32'h0000_1000
) (
    input  wire logic           clk,
    input  wire logic           rst_n_i,

    input  wire logic           in_valid_i,
    input  wire isa_pkg::word_t in_instr_i,
    output logic                in_ready_o,

    output logic                push_valid_o,
    output pipe_pkg::pc_t       push_pc_o,
    output isa_pkg::word_t      push_instr_o,
    input  wire logic           push_ready_i
);

    localparam pipe_pkg::pc_t PC_STEP = 32'd4;

    pipe_pkg::pc_t  pc_q;           // address of the next accepted word
    logic           full_q;
    pipe_pkg::pc_t  out_pc_q;
    isa_pkg::word_t out_instr_q;
    logic           accept;

    // take a new word when the slot is free or is emptied this cycle
    assign in_ready_o = !full_q || push_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            pc_q   <= RESET_PC;
            full_q <= 1'b0;
        end
        else if (accept)
        begin
            pc_q   <= pc_q + PC_STEP;   // advance only on acceptance
            full_q <= 1'b1;
        end
        else if (push_ready_i)
        begin
            full_q <= 1'b0;             // drained with nothing behind it
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_pc_q    <= pc_q;
            out_instr_q <= in_instr_i;
        end
    end

    assign push_valid_o = full_q;
    assign push_pc_o    = out_pc_q;
    assign push_instr_o = out_instr_q;

endmodule : fetch_unit

`default_nettype wire

//--- src/instr_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module instr_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic           clk,
    input  wire logic           rst_n_i,

    input  wire logic           push_valid_i,
    input  wire pipe_pkg::pc_t  push_pc_i,
    input  wire isa_pkg::word_t push_instr_i,
    output logic                push_ready_o,

    output logic                pop_valid_o,
    output pipe_pkg::pc_t       pop_pc_o,
    output isa_pkg::word_t      pop_instr_o,
    input  wire logic           pop_ready_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // pointers carry one extra bit so that full and empty can be told apart
    logic [PTR_W:0] wr_ptr_q;
    logic [PTR_W:0] rd_ptr_q;

    pipe_pkg::pc_t  pc_mem    [FIFO_DEPTH];
    isa_pkg::word_t instr_mem [FIFO_DEPTH];

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);   // same slot, other lap

    assign push_ready_o = !full;
    assign pop_valid_o  = !empty;

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;   // pop fires on a valid head and a ready consumer

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_q + (PTR_W+1)'(1);
            if (pop)
                rd_ptr_q <= rd_ptr_q + (PTR_W+1)'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            pc_mem[wr_ptr_q[PTR_W-1:0]]    <= push_pc_i;
            instr_mem[wr_ptr_q[PTR_W-1:0]] <= push_instr_i;
        end
    end

    assign pop_pc_o    = pc_mem[rd_ptr_q[PTR_W-1:0]];
    assign pop_instr_o = instr_mem[rd_ptr_q[PTR_W-1:0]];

endmodule : instr_fifo

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire logic              clk,
    input  wire logic              rst_n_i,

    input  wire logic              we_i,
    input  wire isa_pkg::reg_idx_t waddr_i,
    input  wire isa_pkg::word_t    wdata_i,

    input  wire isa_pkg::reg_idx_t raddr_a_i,
    input  wire isa_pkg::reg_idx_t raddr_b_i,
    output isa_pkg::word_t         rdata_a_o,
    output isa_pkg::word_t         rdata_b_o
);

    // x0 has no storage
    isa_pkg::word_t regs_q [1:isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < isa_pkg::NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (we_i && waddr_i != '0)
        begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    function automatic isa_pkg::word_t read_reg(input isa_pkg::reg_idx_t addr);
        isa_pkg::word_t data;
        if (addr == '0)
            data = '0;                      // hardwired zero wins over any write
        else if (we_i && waddr_i == addr)
            data = wdata_i;                 // write-through for a same-cycle write
        else
            data = regs_q[addr];
        return data;
    endfunction

    always_comb
    begin
        rdata_a_o = read_reg(raddr_a_i);
        rdata_b_o = read_reg(raddr_b_i);
    end

endmodule : regfile

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              rst_n_i,

    input  wire logic              pop_valid_i,
    input  wire pipe_pkg::pc_t     pop_pc_i,
    input  wire isa_pkg::word_t    pop_instr_i,
    output logic                   pop_ready_o,

    input  wire logic              wb_en_i,
    input  wire isa_pkg::reg_idx_t wb_idx_i,
    input  wire isa_pkg::word_t    wb_data_i,

    output logic                   out_valid_o,
    output pipe_pkg::pc_t          out_pc_o,
    output isa_pkg::opcode_e       out_opcode_o,
    output logic [2:0]             out_funct3_o,
    output logic [6:0]             out_funct7_o,
    output isa_pkg::reg_idx_t      out_rd_o,
    output isa_pkg::reg_idx_t      out_rs1_o,
    output isa_pkg::reg_idx_t      out_rs2_o,
    output isa_pkg::word_t         out_rs1_data_o,
    output isa_pkg::word_t         out_rs2_data_o,
    output isa_pkg::word_t         out_imm_o,
    output isa_pkg::imm_fmt_e      out_fmt_o,
    output logic                   out_illegal_o,
    input  wire logic              out_ready_i
);

    pipe_pkg::out_state_e state_q;
    pipe_pkg::out_state_e state_d;
    logic                 pop_fire;

    isa_pkg::opcode_e     opcode;
    isa_pkg::imm_fmt_e    fmt;
    logic                 illegal;
    isa_pkg::word_t       imm;
    isa_pkg::reg_idx_t    rs1;
    isa_pkg::reg_idx_t    rs2;
    isa_pkg::word_t       rs1_data;
    isa_pkg::word_t       rs2_data;

    assign rs1 = pop_instr_i[19:15];
    assign rs2 = pop_instr_i[24:20];

    always_comb
    begin
        opcode  = isa_pkg::opcode_e'(pop_instr_i[6:0]);
        illegal = 1'b0;
        case (opcode)
            isa_pkg::op_lui, isa_pkg::op_auipc:                fmt = isa_pkg::fmt_u;
            isa_pkg::op_jal:                                   fmt = isa_pkg::fmt_j;
            isa_pkg::op_jalr, isa_pkg::op_load, isa_pkg::op_imm: fmt = isa_pkg::fmt_i;
            isa_pkg::op_branch:                                fmt = isa_pkg::fmt_b;
            isa_pkg::op_store:                                 fmt = isa_pkg::fmt_s;
            isa_pkg::op_reg:                                   fmt = isa_pkg::fmt_r;
            default:
            begin
                fmt     = isa_pkg::fmt_r;   // flagged only, nothing traps here
                illegal = 1'b1;
            end
        endcase

        // only the immediate of the selected format is built
        case (fmt)
            isa_pkg::fmt_i: imm = {{21{pop_instr_i[31]}}, pop_instr_i[30:20]};
            isa_pkg::fmt_s: imm = {{21{pop_instr_i[31]}}, pop_instr_i[30:25], pop_instr_i[11:7]};
            isa_pkg::fmt_b: imm = {{20{pop_instr_i[31]}}, pop_instr_i[7], pop_instr_i[30:25],
                                   pop_instr_i[11:8], 1'b0};
            isa_pkg::fmt_u: imm = {pop_instr_i[31:12], 12'h000};
            isa_pkg::fmt_j: imm = {{12{pop_instr_i[31]}}, pop_instr_i[19:12], pop_instr_i[20],
                                   pop_instr_i[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    regfile i_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_en_i),
        .waddr_i   (wb_idx_i),
        .wdata_i   (wb_data_i),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    // output register takes a new entry when empty or when its entry leaves
    assign pop_ready_o = (state_q == pipe_pkg::out_empty) || out_ready_i;
    assign pop_fire    = pop_valid_i && pop_ready_o;

    always_comb
    begin
        state_d = state_q;
        if (pop_fire)
            state_d = pipe_pkg::out_full;
        else if (out_ready_i)
            state_d = pipe_pkg::out_empty;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            state_q <= pipe_pkg::out_empty;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (pop_fire)
        begin
            out_pc_o       <= pop_pc_i;
            out_opcode_o   <= opcode;
            out_funct3_o   <= pop_instr_i[14:12];
            out_funct7_o   <= pop_instr_i[31:25];
            out_rd_o       <= pop_instr_i[11:7];
            out_rs1_o      <= rs1;
            out_rs2_o      <= rs2;
            out_rs1_data_o <= rs1_data;     // includes a write on this same edge
            out_rs2_data_o <= rs2_data;
            out_imm_o      <= imm;
            out_fmt_o      <= fmt;
            out_illegal_o  <= illegal;
        end
    end

    assign out_valid_o = (state_q == pipe_pkg::out_full);

endmodule : decode_stage

`default_nettype wire

//--- src/decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top #(
    parameter pipe_pkg::pc_t RESET_PC   = 32'h0000_1000,
    parameter int            FIFO_DEPTH = 4             // power of two
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,

    input  wire logic              in_valid_i,
    input  wire isa_pkg::word_t    in_instr_i,
    output logic                   in_ready_o,

    input  wire logic              wb_en_i,
    input  wire isa_pkg::reg_idx_t wb_idx_i,
    input  wire isa_pkg::word_t    wb_data_i,

    output logic                   out_valid_o,
    output pipe_pkg::pc_t          out_pc_o,
    output isa_pkg::opcode_e       out_opcode_o,
    output logic [2:0]             out_funct3_o,
    output logic [6:0]             out_funct7_o,
    output isa_pkg::reg_idx_t      out_rd_o,
    output isa_pkg::reg_idx_t      out_rs1_o,
    output isa_pkg::reg_idx_t      out_rs2_o,
    output isa_pkg::word_t         out_rs1_data_o,
    output isa_pkg::word_t         out_rs2_data_o,
    output isa_pkg::word_t         out_imm_o,
    output isa_pkg::imm_fmt_e      out_fmt_o,
    output logic                   out_illegal_o,
    input  wire logic              out_ready_i
);

    logic           push_valid;
    pipe_pkg::pc_t  push_pc;
    isa_pkg::word_t push_instr;
    logic           push_ready;

    logic           pop_valid;
    pipe_pkg::pc_t  pop_pc;
    isa_pkg::word_t pop_instr;
    logic           pop_ready;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_instr_i   (in_instr_i),
        .in_ready_o   (in_ready_o),
        .push_valid_o (push_valid),
        .push_pc_o    (push_pc),
        .push_instr_o (push_instr),
        .push_ready_i (push_ready)
    );

    instr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_instr_fifo (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (push_valid),
        .push_pc_i    (push_pc),
        .push_instr_i (push_instr),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_pc_o     (pop_pc),
        .pop_instr_o  (pop_instr),
        .pop_ready_i  (pop_ready)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pop_valid_i    (pop_valid),
        .pop_pc_i       (pop_pc),
        .pop_instr_i    (pop_instr),
        .pop_ready_o    (pop_ready),
        .wb_en_i        (wb_en_i),
        .wb_idx_i       (wb_idx_i),
        .wb_data_i      (wb_data_i),
        .out_valid_o    (out_valid_o),
        .out_pc_o       (out_pc_o),
        .out_opcode_o   (out_opcode_o),
        .out_funct3_o   (out_funct3_o),
        .out_funct7_o   (out_funct7_o),
        .out_rd_o       (out_rd_o),
        .out_rs1_o      (out_rs1_o),
        .out_rs2_o      (out_rs2_o),
        .out_rs1_data_o (out_rs1_data_o),
        .out_rs2_data_o (out_rs2_data_o),
        .out_imm_o      (out_imm_o),
        .out_fmt_o      (out_fmt_o),
        .out_illegal_o  (out_illegal_o),
        .out_ready_i    (out_ready_i)
    );

endmodule : decode_top

`default_nettype wire

//--- test/decode_props.sv
`timescale 1ns/1ns
`default_nettype none

module decode_props (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        valid_i,
    input  wire logic        ready_i,
    input  wire logic [63:0] data_i,
    input  wire logic        full_i,
    input  wire logic        push_i,
    input  wire logic [4:0]  idx_i,
    input  wire logic [31:0] idx_data_i
);

    int unsigned fail_count = 0;    // read by the testbench at the end of the run

    // a stalled producer keeps its offer until the transfer
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i && $stable(data_i))
    else
    begin
        $error("valid dropped or data changed while stalled");
        fail_count++;
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        full_i |-> !push_i)
    else
    begin
        $error("push accepted while the FIFO is full");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk) !rst_n_i |=> !valid_i)
    else
    begin
        $error("valid high right after a reset edge");
        fail_count++;
    end

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i && idx_i == 5'd0 |-> idx_data_i == 32'd0)
    else
    begin
        $error("register x0 read back as nonzero");
        fail_count++;
    end

endmodule : decode_props

`default_nettype wire

//--- test/decode_checker.sv
`timescale 1ns/1ns
`default_nettype none

module decode_checker #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        in_valid_i,
    input  wire logic [31:0] in_instr_i,
    input  wire logic        in_ready_i,
    input  wire logic        wb_en_i,
    input  wire logic [4:0]  wb_idx_i,
    input  wire logic [31:0] wb_data_i,
    input  wire logic        pop_fire_i,
    input  wire logic        out_valid_i,
    input  wire logic        out_ready_i,
    input  wire logic [31:0] out_pc_i,
    input  wire logic [6:0]  out_opcode_i,
    input  wire logic [2:0]  out_funct3_i,
    input  wire logic [6:0]  out_funct7_i,
    input  wire logic [4:0]  out_rd_i,
    input  wire logic [4:0]  out_rs1_i,
    input  wire logic [4:0]  out_rs2_i,
    input  wire logic [31:0] out_rs1_data_i,
    input  wire logic [31:0] out_rs2_data_i,
    input  wire logic [31:0] out_imm_i,
    input  wire logic [2:0]  out_fmt_i,
    input  wire logic        out_illegal_i,
    input  wire logic        lat_check_i,   // only meaningful while out_ready_i stays high
    output int               out_count_o,
    output int               err_count_o
);

    logic [31:0] shadow [32];
    logic [31:0] pc;
    logic [31:0] acc_instr_q [$];
    logic [31:0] acc_pc_q [$];
    int          acc_cyc_q [$];
    logic [31:0] dec_instr_q [$];
    logic [31:0] dec_pc_q [$];
    logic [31:0] dec_a_q [$];
    logic [31:0] dec_b_q [$];
    int          dec_cyc_q [$];
    int          cycle = 0;
    int          outs = 0;
    int          errs = 0;
    logic        in_reset_q = 1'b0;
    logic [31:0] w;
    logic [2:0]  fmt;

    assign out_count_o = outs;
    assign err_count_o = errs;

    function automatic logic [2:0] fmt_of(input logic [6:0] opc);
        case (opc)
            7'b0110111, 7'b0010111:             return 3'(isa_pkg::fmt_u);
            7'b1101111:                         return 3'(isa_pkg::fmt_j);
            7'b1100111, 7'b0000011, 7'b0010011: return 3'(isa_pkg::fmt_i);
            7'b1100011:                         return 3'(isa_pkg::fmt_b);
            7'b0100011:                         return 3'(isa_pkg::fmt_s);
            default:                            return 3'(isa_pkg::fmt_r);
        endcase
    endfunction

    function automatic logic known_op(input logic [6:0] opc);
        return opc inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                           7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] i, input logic [2:0] f);
        if (f == 3'(isa_pkg::fmt_i))
            return {{20{i[31]}}, i[31:20]};
        if (f == 3'(isa_pkg::fmt_s))
            return {{20{i[31]}}, i[31:25], i[11:7]};
        if (f == 3'(isa_pkg::fmt_b))
            return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        if (f == 3'(isa_pkg::fmt_u))
            return {i[31:12], 12'h000};
        if (f == 3'(isa_pkg::fmt_j))
            return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        return 32'h0;   // R format and unknown opcodes
    endfunction

    // a write on the reading edge is already visible
    function automatic logic [31:0] read_shadow(input logic [4:0] idx);
        if (idx == 5'd0)
            return 32'h0;
        if (wb_en_i && wb_idx_i == idx)
            return wb_data_i;
        return shadow[idx];
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    always @(posedge clk)
    begin
        if (in_reset_q && out_valid_i === 1'b1)
        begin
            $display("out_valid_o was high while reset was applied");
            errs++;
        end
        in_reset_q = !rst_n_i;
        if (!rst_n_i)
        begin
            pc = RESET_PC;
            foreach (shadow[k])
                shadow[k] = 32'h0;
            acc_instr_q.delete();
            acc_pc_q.delete();
            acc_cyc_q.delete();
            dec_instr_q.delete();
            dec_pc_q.delete();
            dec_a_q.delete();
            dec_b_q.delete();
            dec_cyc_q.delete();
        end
        else
        begin
            if (out_valid_i && out_ready_i)
            begin
                if (dec_instr_q.size() == 0)
                begin
                    $display("an output was offered with no decoded word pending");
                    errs++;
                end
                else
                begin
                    w = dec_instr_q.pop_front();
                    fmt = fmt_of(w[6:0]);
                    check_field("out_pc_o", dec_pc_q.pop_front(), out_pc_i);
                    check_field("out_opcode_o", 32'(w[6:0]), 32'(out_opcode_i));
                    check_field("out_funct3_o", 32'(w[14:12]), 32'(out_funct3_i));
                    check_field("out_funct7_o", 32'(w[31:25]), 32'(out_funct7_i));
                    check_field("out_rd_o", 32'(w[11:7]), 32'(out_rd_i));
                    check_field("out_rs1_o", 32'(w[19:15]), 32'(out_rs1_i));
                    check_field("out_rs2_o", 32'(w[24:20]), 32'(out_rs2_i));
                    check_field("out_rs1_data_o", dec_a_q.pop_front(), out_rs1_data_i);
                    check_field("out_rs2_data_o", dec_b_q.pop_front(), out_rs2_data_i);
                    check_field("out_fmt_o", 32'(fmt), 32'(out_fmt_i));
                    check_field("out_imm_o", imm_of(w, fmt), out_imm_i);
                    check_field("out_illegal_o", 32'(!known_op(w[6:0])), 32'(out_illegal_i));
                    if (lat_check_i && cycle - dec_cyc_q[0] != 3)
                    begin
                        $display("word %h came out %0d cycles after accept, not 3",
                                 w, cycle - dec_cyc_q[0]);
                        errs++;
                    end
                    void'(dec_cyc_q.pop_front());
                    outs++;
                end
            end
            if (pop_fire_i)
            begin
                if (acc_instr_q.size() == 0)
                begin
                    $display("the decode stage popped a word that was never accepted");
                    errs++;
                end
                else
                begin
                    w = acc_instr_q.pop_front();
                    dec_instr_q.push_back(w);
                    dec_pc_q.push_back(acc_pc_q.pop_front());
                    dec_cyc_q.push_back(acc_cyc_q.pop_front());
                    dec_a_q.push_back(read_shadow(w[19:15]));
                    dec_b_q.push_back(read_shadow(w[24:20]));
                end
            end
            if (in_valid_i && in_ready_i)
            begin
                acc_instr_q.push_back(in_instr_i);
                acc_pc_q.push_back(pc);
                acc_cyc_q.push_back(cycle);
                pc = pc + 32'd4;
            end
            if (wb_en_i && wb_idx_i != 5'd0)
                shadow[wb_idx_i] = wb_data_i;
        end
        cycle++;
    end

endmodule : decode_checker

`default_nettype wire

//--- test/tb_decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_top;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int NUM_ROWS = 6;
    localparam int MAX_W    = 6;

    logic        clk;
    logic        rst_n_i;
    logic        in_valid_i;
    logic [31:0] in_instr_i;
    logic        in_ready_o;
    logic        wb_en_i;
    logic [4:0]  wb_idx_i;
    logic [31:0] wb_data_i;
    logic        out_ready_i;
    logic        lat_check;
    int          out_count;
    int          err_count;

    // stimulus table, one row per test
    logic [4:0]  pre_idx   [NUM_ROWS][2];
    logic [31:0] pre_data  [NUM_ROWS][2];
    logic        late_en   [NUM_ROWS];      // write that lands on the first pop edge
    logic [4:0]  late_idx  [NUM_ROWS];
    logic [31:0] late_data [NUM_ROWS];
    logic        rand_rdy  [NUM_ROWS];
    logic        rst_first [NUM_ROWS];
    int          n_words   [NUM_ROWS];
    logic [31:0] words     [NUM_ROWS][MAX_W];

    logic [31:0] lfsr = 32'h41d5_169d;
    logic        table_ready = 1'b0;
    int          wd_cycles;

    decode_top #(
        .RESET_PC   (RESET_PC),
        .FIFO_DEPTH (4)
    ) i_decode_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_instr_i     (in_instr_i),
        .in_ready_o     (in_ready_o),
        .wb_en_i        (wb_en_i),
        .wb_idx_i       (wb_idx_i),
        .wb_data_i      (wb_data_i),
        .out_valid_o    (),
        .out_pc_o       (),
        .out_opcode_o   (),
        .out_funct3_o   (),
        .out_funct7_o   (),
        .out_rd_o       (),
        .out_rs1_o      (),
        .out_rs2_o      (),
        .out_rs1_data_o (),
        .out_rs2_data_o (),
        .out_imm_o      (),
        .out_fmt_o      (),
        .out_illegal_o  (),
        .out_ready_i    (out_ready_i)
    );

    decode_checker #(
        .RESET_PC (RESET_PC)
    ) i_decode_checker (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_instr_i     (in_instr_i),
        .in_ready_i     (in_ready_o),
        .wb_en_i        (wb_en_i),
        .wb_idx_i       (wb_idx_i),
        .wb_data_i      (wb_data_i),
        .pop_fire_i     (i_decode_top.pop_valid && i_decode_top.pop_ready),
        .out_valid_i    (i_decode_top.out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_pc_i       (i_decode_top.out_pc_o),
        .out_opcode_i   (i_decode_top.out_opcode_o),
        .out_funct3_i   (i_decode_top.out_funct3_o),
        .out_funct7_i   (i_decode_top.out_funct7_o),
        .out_rd_i       (i_decode_top.out_rd_o),
        .out_rs1_i      (i_decode_top.out_rs1_o),
        .out_rs2_i      (i_decode_top.out_rs2_o),
        .out_rs1_data_i (i_decode_top.out_rs1_data_o),
        .out_rs2_data_i (i_decode_top.out_rs2_data_o),
        .out_imm_i      (i_decode_top.out_imm_o),
        .out_fmt_i      (i_decode_top.out_fmt_o),
        .out_illegal_i  (i_decode_top.out_illegal_o),
        .lat_check_i    (lat_check),
        .out_count_o    (out_count),
        .err_count_o    (err_count)
    );

    // occupancy comes from the pointer difference and not from the full flag
    bind instr_fifo decode_props i_fifo_props (
        .clk (clk), .rst_n_i (rst_n_i), .valid_i (pop_valid_o), .ready_i (pop_ready_i),
        .data_i ({pop_pc_o, pop_instr_o}), .push_i (push),
        .full_i (wr_ptr_q - rd_ptr_q == (PTR_W+1)'(FIFO_DEPTH)),
        .idx_i (5'd0), .idx_data_i (32'd0)
    );

    bind decode_stage decode_props i_out_props (
        .clk (clk), .rst_n_i (rst_n_i), .valid_i (out_valid_o), .ready_i (out_ready_i),
        .data_i ({out_pc_o, out_imm_o}), .full_i (1'b0), .push_i (1'b0),
        .idx_i (out_rs1_o), .idx_data_i (out_rs1_data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic set_row(input int r, input logic [4:0] i0, input logic [31:0] d0,
                           input logic [4:0] i1, input logic [31:0] d1, input logic le,
                           input logic [4:0] li, input logic [31:0] ld, input logic rnd,
                           input logic rst, input int n, input logic [31:0] w [MAX_W]);
        pre_idx[r][0]  = i0;
        pre_data[r][0] = d0;
        pre_idx[r][1]  = i1;
        pre_data[r][1] = d1;
        late_en[r]     = le;
        late_idx[r]    = li;
        late_data[r]   = ld;
        rand_rdy[r]    = rnd;
        rst_first[r]   = rst;
        n_words[r]     = n;
        words[r]       = w;
    endtask

    task automatic drive_ready(input logic rnd);
        if (rnd)
        begin
            lfsr        = lfsr_next(lfsr);
            out_ready_i = lfsr[0];
        end
        else
            out_ready_i = 1'b1;
    endtask

    task automatic run_row(input int r);
        int   sent;
        int   late_cnt;
        int   target;
        logic accepted;
        sent      = 0;
        late_cnt  = 0;
        target    = out_count + n_words[r];
        lat_check = !rand_rdy[r];
        if (rst_first[r])
        begin
            // one word waits in the output register so the reset has something to clear
            in_valid_i  = 1'b1;
            in_instr_i  = words[r][0];
            out_ready_i = 1'b0;
            @(posedge clk);
            #2 in_valid_i = 1'b0;
            while (i_decode_top.out_valid_o !== 1'b1)
            begin
                @(posedge clk);
                #2;
            end
            rst_n_i = 1'b0;
            repeat (4) @(posedge clk);
            #2 rst_n_i = 1'b1;
        end
        for (int k = 0; k < 2; k++)
        begin
            wb_en_i   = 1'b1;
            wb_idx_i  = pre_idx[r][k];
            wb_data_i = pre_data[r][k];
            @(posedge clk);
            #2 wb_en_i = 1'b0;
        end
        while (sent < n_words[r])
        begin
            in_valid_i = 1'b1;
            in_instr_i = words[r][sent];
            wb_en_i    = late_en[r] && late_cnt == 1;
            wb_idx_i   = late_idx[r];
            wb_data_i  = late_data[r];
            drive_ready(rand_rdy[r]);
            @(negedge clk);
            accepted = in_ready_o;
            @(posedge clk);
            #2;
            if (late_cnt > 0)
                late_cnt--;
            if (accepted)
            begin
                if (sent == 0)
                    late_cnt = 2;   // first word is popped two edges after its accept
                sent++;
            end
        end
        in_valid_i = 1'b0;
        wb_en_i    = 1'b0;
        while (out_count < target)
        begin
            drive_ready(rand_rdy[r]);
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin
        int errs_before;
        int row_errs;
        int props_fails;
        int passed;
        int failed;
        passed      = 0;
        failed      = 0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_instr_i  = 32'h0;
        wb_en_i     = 1'b0;
        wb_idx_i    = 5'd0;
        wb_data_i   = 32'h0;
        out_ready_i = 1'b1;
        lat_check   = 1'b0;

        // R, I and S with a negative immediate
        set_row(0, 5'd1, 32'h1111_1111, 5'd2, 32'hffff_0002, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 3,
                '{32'h0020_81b3, 32'hffb0_8213, 32'hfe20_ac23, 32'h0, 32'h0, 32'h0});
        // B, U, J and the remaining I opcodes
        set_row(1, 5'd3, 32'h0000_0333, 5'd4, 32'h8000_0004, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 6,
                '{32'hfe20_88e3, 32'habcd_e2b7, 32'hf55f_f0ef, 32'h1234_5517, 32'hffc0_8067,
                  32'h0040_a183});
        // x0 write is dropped and x7 arrives on the pop edge
        set_row(2, 5'd6, 32'h0000_6666, 5'd0, 32'hdead_beef, 1'b1, 5'd7, 32'h7777_0007, 1'b0,
                1'b0, 3, '{32'h0063_8433, 32'h0000_04b3, 32'h0003_0513, 32'h0, 32'h0, 32'h0});
        set_row(3, 5'd1, 32'h0123_4567, 5'd2, 32'h89ab_cdef, 1'b0, 5'd0, 32'h0, 1'b1, 1'b0, 6,
                '{32'h0020_8033, 32'h4020_8133, 32'hfff0_a093, 32'h0011_2423, 32'h8000_00ef,
                  32'hffff_f537});
        set_row(4, 5'd0, 32'h0000_0001, 5'd9, 32'h0000_0999, 1'b0, 5'd0, 32'h0, 1'b0, 1'b1, 3,
                '{32'h0010_0093, 32'h0020_0113, 32'h0030_80b3, 32'h0, 32'h0, 32'h0});
        // unknown opcodes between legal words
        set_row(5, 5'd10, 32'h0000_0aaa, 5'd11, 32'hffff_fbbb, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0, 5,
                '{32'h0000_007f, 32'h1234_5678, 32'h00a0_0513, 32'hffff_fffb, 32'h0000_000f,
                  32'h0});

        wd_cycles = 200;
        for (int r = 0; r < NUM_ROWS; r++)
            wd_cycles += 20 * n_words[r];
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        #2 rst_n_i = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            errs_before = err_count;
            run_row(r);
            row_errs = err_count - errs_before;
            $display("test %0d: %0d words, %0d mismatches", r, n_words[r], row_errs);
            if (row_errs == 0)
                passed++;
            else
                failed++;
        end

        props_fails = i_decode_top.i_instr_fifo.i_fifo_props.fail_count
                    + i_decode_top.i_decode_stage.i_out_props.fail_count;
        $display("summary: %0d tests, %0d ok, %0d bad, %0d mismatches, %0d assertion failures",
                 NUM_ROWS, passed, failed, err_count, props_fails);
        if (failed == 0 && err_count == 0 && props_fails == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        repeat (wd_cycles) @(posedge clk);
        $display("run timed out after %0d cycles with tests unfinished", wd_cycles);
        $display("tests failed");
        $finish;
    end

endmodule : tb_decode_top

`default_nettype wire

//--- all.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/instr_fifo.sv
src/regfile.sv
src/decode_stage.sv
src/decode_top.sv
test/decode_props.sv
test/decode_checker.sv
test/tb_decode_top.sv

//--- run.sh
#!/bin/sh
# build and run the decode front end simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module tb_decode_top -o sim_decode \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_decode +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
